//--- filelist.f
logic/mmuPkg.sv
logic/tlbLookupIf.sv
logic/tlbArray.sv
logic/tlbArbiter.sv
logic/instTlbBuffer.sv
logic/dataTlbBuffer.sv
logic/addrTranslate.sv
sim/addrTranslateProperties.sv
sim/addrTranslateTb.sv

//--- logic/addrTranslate.sv
`timescale 1ns/1ns

module addrTranslate (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [19:0]                    instVpn,
    output logic [19:0]                    instPfn,
    output logic                           instUncached,
    output mmuPkg::excCodeT                instExc,
    output logic                           instStall,
    input  logic [19:0]                    dataVpn,
    input  logic                           dataIsStore,
    output logic [19:0]                    dataPfn,
    output logic                           dataUncached,
    output mmuPkg::excCodeT                dataExc,
    output logic                           dataStall,
    input  logic [2:0]                     configK0,
    input  logic                           tlbWrite,
    input  logic [mmuPkg::tlbIndexW-1:0]   tlbWriteIndex,
    input  mmuPkg::tlbEntryT               tlbWriteEntry
);
    import mmuPkg::*;

    logic [18:0]  lookupVpn2;
    lookupResultT lookupResult;

    tlbLookupIf instLookup ();
    tlbLookupIf dataLookup ();

    tlbArray i_tlbArray (
        .clk          (clk),
        .reset        (reset),
        .write        (tlbWrite),
        .writeIndex   (tlbWriteIndex),
        .writeEntry   (tlbWriteEntry),
        .lookupVpn2   (lookupVpn2),
        .lookupResult (lookupResult)
    );

    tlbArbiter i_tlbArbiter (
        .clk          (clk),
        .reset        (reset),
        .inst         (instLookup),
        .data         (dataLookup),
        .lookupVpn2   (lookupVpn2),
        .lookupResult (lookupResult)
    );

    // a TLB write flushes both buffers
    instTlbBuffer i_instBuffer (
        .clk      (clk),
        .reset    (reset),
        .flush    (tlbWrite),
        .vpn      (instVpn),
        .configK0 (configK0),
        .pfn      (instPfn),
        .uncached (instUncached),
        .exc      (instExc),
        .stall    (instStall),
        .lookup   (instLookup)
    );

    dataTlbBuffer i_dataBuffer (
        .clk      (clk),
        .reset    (reset),
        .flush    (tlbWrite),
        .vpn      (dataVpn),
        .isStore  (dataIsStore),
        .configK0 (configK0),
        .pfn      (dataPfn),
        .uncached (dataUncached),
        .exc      (dataExc),
        .stall    (dataStall),
        .lookup   (dataLookup)
    );

endmodule

//--- logic/dataTlbBuffer.sv
`timescale 1ns/1ns

module dataTlbBuffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic [19:0]       vpn,
    input  logic              isStore,
    input  logic [2:0]        configK0,
    output logic [19:0]       pfn,
    output logic              uncached,
    output mmuPkg::excCodeT   exc,
    output logic              stall,
    tlbLookupIf.requester     lookup
);
    import mmuPkg::*;

    bufStateT     state;
    bufStateT     nextState;
    logic         bufValid;
    logic [18:0]  bufVpn2;
    lookupResultT bufEntry;
    tlbPageT      selPage;
    logic         unmapped;
    logic         kseg1;
    logic         bufHit;
    logic         load;

    assign unmapped = (vpn[19:18] == 2'b10); // kseg0 or kseg1
    assign kseg1 = (vpn[19:17] == 3'b101);
    assign selPage = vpn[0] ? bufEntry.page1 : bufEntry.page0;

    assign bufHit = unmapped || (bufValid && bufVpn2 == vpn[19:1]);
    assign stall = !bufHit;

    always_comb begin
        if (kseg1) begin
            pfn = {3'b000, vpn[16:0]};
        end else if (unmapped) begin
            pfn = {1'b0, vpn[18:0]};
        end else begin
            pfn = selPage.pfn;
        end
    end

    always_comb begin
        if (kseg1) begin
            uncached = 1'b1;
        end else if (unmapped) begin
            uncached = (configK0 != cacheableAttr); // K0 field sets kseg0 caching
        end else begin
            uncached = (selPage.c != cacheableAttr);
        end
    end

    // store variants for refill and invalid, then the dirty check
    always_comb begin
        exc = noEx;
        if (!unmapped && bufHit) begin
            if (!bufEntry.found) begin
                exc = isStore ? tlbRefillStore : tlbRefillLoad;
            end else if (!selPage.v) begin
                exc = isStore ? tlbInvalidStore : tlbInvalidLoad;
            end else if (isStore && !selPage.d) begin
                exc = tlbModified; // page not writable
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle:   if (!bufHit) nextState = search;
            search: if (lookup.gnt) nextState = idle;
            default: nextState = idle;
        endcase
    end

    assign lookup.req = (state == search);
    assign lookup.vpn2 = vpn[19:1];
    assign load = lookup.req && lookup.gnt;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            bufValid <= 1'b0;
        end else if (load) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bufVpn2 <= vpn[19:1];
            bufEntry <= lookup.result;
        end
    end

endmodule

//--- logic/instTlbBuffer.sv
`timescale 1ns/1ns

module instTlbBuffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic [19:0]       vpn,
    input  logic [2:0]        configK0,
    output logic [19:0]       pfn,
    output logic              uncached,
    output mmuPkg::excCodeT   exc,
    output logic              stall,
    tlbLookupIf.requester     lookup
);
    import mmuPkg::*;

    bufStateT     state;
    bufStateT     nextState;
    logic         bufValid;
    logic [18:0]  bufVpn2;
    lookupResultT bufEntry;
    tlbPageT      selPage;
    logic         unmapped;
    logic         kseg1;
    logic         bufHit;
    logic         load;

    assign unmapped = (vpn[19:18] == 2'b10); // 0x8 to 0xB
    assign kseg1 = (vpn[19:17] == 3'b101);
    assign selPage = vpn[0] ? bufEntry.page1 : bufEntry.page0; // odd or even page

    assign bufHit = unmapped || (bufValid && bufVpn2 == vpn[19:1]);
    assign stall = !bufHit;

    always_comb begin
        if (kseg1) begin
            pfn = {3'b000, vpn[16:0]};
        end else if (unmapped) begin
            pfn = {1'b0, vpn[18:0]}; // kseg0
        end else begin
            pfn = selPage.pfn;
        end
    end

    always_comb begin
        if (kseg1) begin
            uncached = 1'b1;
        end else if (unmapped) begin
            uncached = (configK0 != cacheableAttr);
        end else begin
            uncached = (selPage.c != cacheableAttr);
        end
    end

    // no exception until the buffer holds this page pair
    always_comb begin
        exc = noEx;
        if (!unmapped && bufHit) begin
            if (!bufEntry.found) begin
                exc = tlbRefillLoad;
            end else if (!selPage.v) begin
                exc = tlbInvalidLoad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle:   if (!bufHit) nextState = search;
            search: if (lookup.gnt) nextState = idle;
            default: nextState = idle;
        endcase
    end

    assign lookup.req = (state == search);
    assign lookup.vpn2 = vpn[19:1];
    assign load = lookup.req && lookup.gnt;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            bufValid <= 1'b0;
        end else if (load) begin
            bufValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            bufVpn2 <= vpn[19:1];
            bufEntry <= lookup.result;
        end
    end

endmodule

//--- logic/mmuPkg.sv
package mmuPkg;

    localparam int tlbEntries = 16;
    localparam int tlbIndexW = 4;
    localparam logic [2:0] cacheableAttr = 3'd3; // cached, noncoherent

    // one half of an even/odd page pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d; // writable
        logic        v;
    } tlbPageT;

    typedef struct packed {
        logic        valid;
        logic [18:0] vpn2;
        tlbPageT     page0; // even page
        tlbPageT     page1; // odd page
    } tlbEntryT;

    typedef struct packed {
        logic    found;
        tlbPageT page0;
        tlbPageT page1;
    } lookupResultT;

    // low four bits carry the MIPS ExcCode
    // bit 4 marks a refill, which takes the refill vector instead of the general one
    typedef enum logic [4:0] {
        noEx            = 5'h00,
        tlbModified     = 5'h01,
        tlbInvalidLoad  = 5'h02,
        tlbInvalidStore = 5'h03,
        tlbRefillLoad   = 5'h12,
        tlbRefillStore  = 5'h13
    } excCodeT;

    typedef enum logic {idle, search} bufStateT;

endpackage

//--- logic/tlbArbiter.sv
`timescale 1ns/1ns

module tlbArbiter (
    input  logic                  clk,
    input  logic                  reset,
    tlbLookupIf.arbiter           inst,
    tlbLookupIf.arbiter           data,
    output logic [18:0]           lookupVpn2,
    input  mmuPkg::lookupResultT  lookupResult
);

    logic preferData; // round-robin pointer
    logic contested;

    assign contested = inst.req && data.req;

    // grant in the same cycle as the request
    assign data.gnt = data.req && (!inst.req || preferData);
    assign inst.gnt = inst.req && (!data.req || !preferData);

    always_ff @(posedge clk) begin
        if (reset) begin
            preferData <= 1'b1; // data side wins first
        end else if (contested) begin
            preferData <= !preferData;
        end
    end

    // steer the granted address to the single lookup port
    assign lookupVpn2 = data.gnt ? data.vpn2 : inst.vpn2;

    // both sides see the result but only the granted one loads it
    assign inst.result = lookupResult;
    assign data.result = lookupResult;

endmodule

//--- logic/tlbArray.sv
`timescale 1ns/1ns

module tlbArray (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           write,
    input  logic [mmuPkg::tlbIndexW-1:0]   writeIndex,
    input  mmuPkg::tlbEntryT               writeEntry,
    input  logic [18:0]                    lookupVpn2,
    output mmuPkg::lookupResultT           lookupResult
);
    import mmuPkg::*;

    tlbEntryT              entries [tlbEntries];
    logic [tlbEntries-1:0] entryValid;
    logic [tlbEntries-1:0] matchVec;
    logic [tlbIndexW-1:0]  hitIndex;

    // only the valid bits need clearing
    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (write) begin
            entryValid[writeIndex] <= writeEntry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // parallel compare of all entries
    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            matchVec[i] = entryValid[i] && (entries[i].vpn2 == lookupVpn2);
        end
    end

    // lowest matching index wins
    always_comb begin
        hitIndex = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                hitIndex = tlbIndexW'(i);
            end
        end
    end

    always_comb begin
        lookupResult.found = |matchVec;
        lookupResult.page0 = entries[hitIndex].page0;
        lookupResult.page1 = entries[hitIndex].page1;
    end

endmodule

//--- logic/tlbLookupIf.sv
`timescale 1ns/1ns

interface tlbLookupIf;
    import mmuPkg::*;

    logic         req;  // level, held while the buffer searches
    logic [18:0]  vpn2;
    logic         gnt;
    lookupResultT result;

    modport requester (
        output req,
        output vpn2,
        input  gnt,
        input  result
    );

    modport arbiter (
        input  req,
        input  vpn2,
        output gnt,
        output result
    );

endinterface

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ns --top-module addrTranslateTb \
    -f filelist.f -o addrTranslateSim &&
./obj_dir/addrTranslateSim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- sim/addrTranslateProperties.sv
`timescale 1ns/1ns

module addrTranslateProperties (
    input logic clk,
    input logic reset,
    input logic instReq,
    input logic instGnt,
    input logic dataReq,
    input logic dataGnt
);

    // single lookup port
    grantsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(instGnt && dataGnt))
        else $error("inst and data grants high together");

    instGntNeedsReq: assert property (@(posedge clk) disable iff (reset) instGnt |-> instReq)
        else $error("inst grant without inst request");

    dataGntNeedsReq: assert property (@(posedge clk) disable iff (reset) dataGnt |-> dataReq)
        else $error("data grant without data request");

    // a request turned away once wins the next cycle
    instNoStarve: assert property (@(posedge clk) disable iff (reset)
        (instReq && $past(instReq && !instGnt)) |-> instGnt)
        else $error("inst request not granted within two cycles");

    dataNoStarve: assert property (@(posedge clk) disable iff (reset)
        (dataReq && $past(dataReq && !dataGnt)) |-> dataGnt)
        else $error("data request not granted within two cycles");

endmodule

bind tlbArbiter addrTranslateProperties i_properties (
    .clk     (clk),
    .reset   (reset),
    .instReq (inst.req),
    .instGnt (inst.gnt),
    .dataReq (data.req),
    .dataGnt (data.gnt)
);

//--- sim/addrTranslateTb.sv
`timescale 1ns/1ns

module addrTranslateTb;
    import mmuPkg::*;

    logic             clk;
    logic             reset;
    logic [19:0]      instVpn;
    logic [19:0]      instPfn;
    logic             instUncached;
    excCodeT          instExc;
    logic             instStall;
    logic [19:0]      dataVpn;
    logic             dataIsStore;
    logic [19:0]      dataPfn;
    logic             dataUncached;
    excCodeT          dataExc;
    logic             dataStall;
    logic [2:0]       configK0;
    logic             tlbWrite;
    logic [tlbIndexW-1:0] tlbWriteIndex;
    tlbEntryT         tlbWriteEntry;

    int          seed = 98541;
    logic [31:0] rnd;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    addrTranslate i_dut (
        .clk           (clk),
        .reset         (reset),
        .instVpn       (instVpn),
        .instPfn       (instPfn),
        .instUncached  (instUncached),
        .instExc       (instExc),
        .instStall     (instStall),
        .dataVpn       (dataVpn),
        .dataIsStore   (dataIsStore),
        .dataPfn       (dataPfn),
        .dataUncached  (dataUncached),
        .dataExc       (dataExc),
        .dataStall     (dataStall),
        .configK0      (configK0),
        .tlbWrite      (tlbWrite),
        .tlbWriteIndex (tlbWriteIndex),
        .tlbWriteEntry (tlbWriteEntry)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic tlbEntryT makeEntry(
        input logic [18:0] vpn2,
        input logic [19:0] pfn0, input logic [2:0] c0, input logic [1:0] dv0,
        input logic [19:0] pfn1, input logic [2:0] c1, input logic [1:0] dv1
    );
        tlbEntryT e;
        e.valid = 1'b1;
        e.vpn2 = vpn2;
        e.page0 = {pfn0, c0, dv0}; // dv is {d, v}
        e.page1 = {pfn1, c1, dv1};
        return e;
    endfunction

    task checkPfn(input string name, input logic [19:0] expected, input logic [19:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch in %s: pfn expected %h, actual %h", name, expected, actual);
        end
    endtask

    task checkExc(input string name, input excCodeT expected, input excCodeT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch in %s: exc expected %s, actual %s", name,
                expected.name(), actual.name());
        end
    endtask

    task checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch in %s: bit expected %b, actual %b", name, expected, actual);
        end
    endtask

    task writeTlb(input logic [tlbIndexW-1:0] index, input tlbEntryT entry);
        @(negedge clk);
        instVpn = 20'h80000; // park both sides in kseg0
        dataVpn = 20'h80000;
        tlbWrite = 1'b1;
        tlbWriteIndex = index;
        tlbWriteEntry = entry;
        @(negedge clk);
        tlbWrite = 1'b0;
    endtask

    // drive both addresses, then wait for both stalls to drop
    task access(input string name, input logic [19:0] iv, input logic [19:0] dv,
                input logic store, output logic sawStall);
        int cycles;
        @(negedge clk);
        instVpn = iv;
        dataVpn = dv;
        dataIsStore = store;
        cycles = 0;
        @(negedge clk);
        sawStall = instStall || dataStall;
        while ((instStall || dataStall) && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (instStall || dataStall) begin
            errorCount++;
            $display("%s: stall never cleared within 20 cycles", name);
        end
    endtask

    task finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task testUnmapped();
        int          errorsBefore;
        logic [19:0] kseg1Vpn;
        logic [19:0] kseg0Vpn;
        logic [19:0] kseg1Pfn;
        logic [19:0] kseg0Pfn;
        logic        k0Uncached;
        logic        saw;
        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            kseg1Vpn = {3'b101, rnd[16:0]};
            kseg0Vpn = {3'b100, rnd[31:15]};
            configK0 = (i % 2 == 0) ? 3'd3 : 3'd2;
            kseg1Pfn = {3'b000, kseg1Vpn[16:0]};
            kseg0Pfn = {1'b0, kseg0Vpn[18:0]};
            k0Uncached = (configK0 != 3'd3);
            if (i < 2) begin
                access("unmapped", kseg1Vpn, kseg0Vpn, 1'b1, saw);
                checkPfn("unmapped", kseg1Pfn, instPfn);
                checkBit("unmapped", 1'b1, instUncached);
                checkPfn("unmapped", kseg0Pfn, dataPfn);
                checkBit("unmapped", k0Uncached, dataUncached);
            end else begin
                access("unmapped", kseg0Vpn, kseg1Vpn, 1'b1, saw); // sides swapped
                checkPfn("unmapped", kseg0Pfn, instPfn);
                checkBit("unmapped", k0Uncached, instUncached);
                checkPfn("unmapped", kseg1Pfn, dataPfn);
                checkBit("unmapped", 1'b1, dataUncached);
            end
            checkBit("unmapped", 1'b0, saw);
            checkExc("unmapped", noEx, instExc);
            checkExc("unmapped", noEx, dataExc);
        end
        finishTest("unmapped", errorsBefore);
    endtask

    task testMappedHit();
        int          errorsBefore;
        logic [19:0] pfnEven;
        logic [19:0] pfnOdd;
        logic        saw;
        errorsBefore = errorCount;
        rnd = $random(seed);
        pfnEven = rnd[19:0];
        rnd = $random(seed);
        pfnOdd = rnd[19:0];
        writeTlb(4'd3, makeEntry(19'h00012, pfnEven, 3'd3, 2'b11, pfnOdd, 3'd2, 2'b11));
        access("mappedHit", 20'h00024, 20'h80000, 1'b0, saw);
        checkBit("mappedHit", 1'b1, saw);
        checkPfn("mappedHit", pfnEven, instPfn);
        checkBit("mappedHit", 1'b0, instUncached);
        checkExc("mappedHit", noEx, instExc);
        access("mappedHit", 20'h00025, 20'h80000, 1'b0, saw); // odd page, same pair
        checkBit("mappedHit", 1'b0, saw);
        checkPfn("mappedHit", pfnOdd, instPfn);
        checkBit("mappedHit", 1'b1, instUncached);
        finishTest("mappedHit", errorsBefore);
    endtask

    task testExceptions();
        int   errorsBefore;
        logic saw;
        errorsBefore = errorCount;
        // even page invalid, odd page valid but clean
        writeTlb(4'd5, makeEntry(19'h00300, 20'h12345, 3'd3, 2'b00, 20'h6789a, 3'd2, 2'b01));
        access("exceptions", 20'h00400, 20'h00400, 1'b0, saw);
        checkExc("exceptions", tlbRefillLoad, instExc);
        checkExc("exceptions", tlbRefillLoad, dataExc);
        access("exceptions", 20'h00400, 20'h00400, 1'b1, saw);
        checkExc("exceptions", tlbRefillStore, dataExc);
        access("exceptions", 20'h00600, 20'h00600, 1'b1, saw);
        checkExc("exceptions", tlbInvalidLoad, instExc);
        checkExc("exceptions", tlbInvalidStore, dataExc);
        access("exceptions", 20'h00600, 20'h00601, 1'b1, saw);
        checkExc("exceptions", tlbModified, dataExc);
        access("exceptions", 20'h00600, 20'h00601, 1'b0, saw);
        checkExc("exceptions", noEx, dataExc);
        checkPfn("exceptions", 20'h6789a, dataPfn);
        checkBit("exceptions", 1'b1, dataUncached);
        finishTest("exceptions", errorsBefore);
    endtask

    task testFlush();
        int          errorsBefore;
        logic [19:0] oldPfn;
        logic [19:0] newPfn;
        logic        saw;
        errorsBefore = errorCount;
        rnd = $random(seed);
        oldPfn = rnd[19:0];
        newPfn = ~rnd[19:0];
        writeTlb(4'd3, makeEntry(19'h00012, oldPfn, 3'd3, 2'b11, oldPfn, 3'd3, 2'b11));
        access("flush", 20'h00024, 20'h80000, 1'b0, saw);
        checkPfn("flush", oldPfn, instPfn);
        writeTlb(4'd3, makeEntry(19'h00012, newPfn, 3'd3, 2'b11, newPfn, 3'd3, 2'b11));
        access("flush", 20'h00024, 20'h80000, 1'b0, saw);
        checkBit("flush", 1'b1, saw);
        checkPfn("flush", newPfn, instPfn);
        finishTest("flush", errorsBefore);
    endtask

    task testContention();
        int          errorsBefore;
        logic [19:0] pfnA;
        logic [19:0] pfnB;
        logic        saw;
        errorsBefore = errorCount;
        rnd = $random(seed);
        pfnA = rnd[19:0];
        rnd = $random(seed);
        pfnB = rnd[19:0];
        writeTlb(4'd7, makeEntry(19'h00100, pfnA, 3'd3, 2'b11, ~pfnA, 3'd3, 2'b11));
        writeTlb(4'd8, makeEntry(19'h00180, pfnB, 3'd3, 2'b11, ~pfnB, 3'd3, 2'b11));
        access("contention", 20'h00200, 20'h00301, 1'b0, saw);
        checkBit("contention", 1'b1, saw);
        checkPfn("contention", pfnA, instPfn);
        checkPfn("contention", ~pfnB, dataPfn);
        // swap sides so both miss again
        access("contention", 20'h00301, 20'h00200, 1'b0, saw);
        checkBit("contention", 1'b1, saw);
        checkPfn("contention", ~pfnB, instPfn);
        checkPfn("contention", pfnA, dataPfn);
        finishTest("contention", errorsBefore);
    endtask

    initial begin
        reset = 1'b1;
        instVpn = 20'h80000;
        dataVpn = 20'h80000;
        dataIsStore = 1'b0;
        configK0 = 3'd3;
        tlbWrite = 1'b0;
        tlbWriteIndex = '0;
        tlbWriteEntry = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        testUnmapped();
        testMappedHit();
        testExceptions();
        testFlush();
        testContention();
        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
